/* logic/img_cap_pkg.sv */
// Shared video timing, FIFO sizing and bundle types, imported by every design and bench file
package img_cap_pkg;

	// ====================
	// 640 x 480 at 60 Hz, one clock per pixel
	// ====================
	localparam int h_active = 640;          // Visible pixels per line
	localparam int h_front  = 16;
	localparam int h_sync   = 96;           // hs low width
	localparam int h_back   = 48;
	localparam int h_total  = 800;          // Full line period

	localparam int v_active = 480;          // Visible lines per frame
	localparam int v_front  = 10;
	localparam int v_sync   = 2;            // vs low width in lines
	localparam int v_back   = 33;
	localparam int v_total  = 525;          // Full frame period

	localparam int h_bits = $clog2(h_total); // Horizontal counter width
	localparam int v_bits = $clog2(v_total); // Vertical counter width

	// Pixel FIFO size, absorbs camera to display phase
	localparam int fifo_depth = 1024;

	// ====================
	// Bundles
	// ====================
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;                             // Camera color

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;                             // HDMI color

	typedef struct packed {
		logic    sof;                       // First pixel of a camera frame
		rgb565_t pixel;
	} cam_pixel_t;

	typedef struct packed {
		logic hs;                           // Active low
		logic vs;                           // Active low
		logic de;
		logic first;                        // First active pixel of the frame
	} video_t;

	typedef struct packed {
		logic streaming;
		logic underrun;
		logic overflow;
	} img_status_t;

endpackage

/* logic/cam_capture.sv */
// Camera bus front end; registers the pins, tags frame starts and pushes pixels into the FIFO
`timescale 1ns/1ns

module cam_capture import img_cap_pkg::*; (
	input  logic       clk_25_2m,
	input  logic       reset,
	input  logic       cam_vsync,
	input  logic       cam_href,
	input  rgb565_t    cam_data,
	output cam_pixel_t pix,
	output logic       pix_valid,
	input  logic       pix_ready,
	output logic       overflow
);

	logic    vsync_q;    // Registered pins
	logic    href_q;
	rgb565_t data_q;
	logic    vsync_prev; // For edge detect
	logic    sof_armed;  // Edge seen, waiting for first pixel
	logic    vsync_fall;
	logic    present;

	// ====================
	// Input registers
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			vsync_q    <= 1'b0;
			href_q     <= 1'b0;
			vsync_prev <= 1'b0;  // Low so a camera already in blanking gives no false edge
		end else begin
			vsync_q    <= cam_vsync;
			href_q     <= cam_href;
			vsync_prev <= vsync_q;
		end
	end

	always_ff @(posedge clk_25_2m) begin
		data_q <= cam_data;     // Pixel payload
	end

	assign vsync_fall = vsync_prev & ~vsync_q;  // End of vertical blanking
	assign present    = href_q & ~vsync_q;      // One pixel per clock in the line

	// ====================
	// Frame start and overflow tracking
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			sof_armed <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			if (present)
				sof_armed <= 1'b0;      // Tag consumed by this pixel
			else if (vsync_fall)
				sof_armed <= 1'b1;
			if (present && !pix_ready)
				overflow <= 1'b1;       // Sticky, camera cannot be stalled
		end
	end

	// Pixel is dropped when the FIFO is full
	assign pix.sof   = sof_armed | vsync_fall;
	assign pix.pixel = data_q;
	assign pix_valid = present;

endmodule

/* logic/pixel_fifo.sv */
// Single clock first-word-fall-through FIFO carrying camera pixels to the stream control
`timescale 1ns/1ns

module pixel_fifo import img_cap_pkg::*; #(
	parameter int depth = fifo_depth
) (
	input  logic       clk_25_2m,
	input  logic       reset,
	input  cam_pixel_t in_data,
	input  logic       in_valid,
	output logic       in_ready,
	output cam_pixel_t out_data,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam int ptr_bits = $clog2(depth);
	localparam int cnt_bits = $clog2(depth + 1);

	cam_pixel_t          mem [depth];   // Storage, no reset
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [cnt_bits-1:0] count;         // Occupancy
	logic                push;
	logic                pop;

	assign in_ready  = count != cnt_bits'(depth);
	assign out_valid = count != '0;
	assign push      = in_valid & in_ready;
	assign pop       = out_valid & out_ready;
	assign out_data  = mem[rd_ptr];     // Head visible without a read request

	always_ff @(posedge clk_25_2m) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)   // Wrap at depth, also for non power of two sizes
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* logic/video_timing.sv */
// 640 x 480 display timing; counters start at the first active pixel and drive the video bundle
`timescale 1ns/1ns

module video_timing import img_cap_pkg::*; (
	input  logic   clk_25_2m,
	input  logic   reset,
	output video_t video
);

	logic [h_bits-1:0] h_cnt;   // Pixel in line with 0 the first active
	logic [v_bits-1:0] v_cnt;   // Line in frame with 0 the first active
	logic              h_last;
	logic              v_last;
	logic              h_in_sync;
	logic              v_in_sync;

	assign h_last = h_cnt == h_bits'(h_total - 1);
	assign v_last = v_cnt == v_bits'(v_total - 1);

	// ====================
	// Counters
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last)
					v_cnt <= '0;                // New frame
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// ====================
	// Decode
	// ====================
	// Per line the order is active, front porch, sync and back porch
	assign h_in_sync = (h_cnt >= h_bits'(h_active + h_front)) &&
		(h_cnt < h_bits'(h_active + h_front + h_sync));
	// Same order in lines
	assign v_in_sync = (v_cnt >= v_bits'(v_active + v_front)) &&
		(v_cnt < v_bits'(v_active + v_front + v_sync));

	always_comb begin
		video.hs    = ~h_in_sync;           // Active low
		video.vs    = ~v_in_sync;           // Active low
		video.de    = (h_cnt < h_bits'(h_active)) && (v_cnt < v_bits'(v_active));
		video.first = (h_cnt == '0) && (v_cnt == '0);
	end

endmodule

/* logic/stream_ctrl.sv */
// Frame lock control; finds a camera frame start, waits for the display frame, then streams
`timescale 1ns/1ns

module stream_ctrl import img_cap_pkg::*; (
	input  logic       clk_25_2m,
	input  logic       reset,
	input  video_t     video,
	input  cam_pixel_t head,
	input  logic       head_valid,
	output logic       head_ready,
	output rgb565_t    pixel,
	output logic       black,
	output logic       streaming,
	output logic       underrun
);

	typedef enum logic [1:0] {
		st_seek,    // Drop words until a frame start
		st_armed,   // Frame start held at the head
		st_stream   // One pop per de cycle
	} state_t;

	state_t state;
	state_t next;
	logic   show;       // Head word goes to the display this cycle
	logic   discard;    // Head word thrown away
	logic   starve;     // Display wants a pixel, FIFO empty

	// ====================
	// Next state
	// ====================
	always_comb begin
		show    = 1'b0;
		discard = 1'b0;
		next    = state;
		case (state)
			st_seek: begin
				if (head_valid && !head.sof)
					discard = 1'b1;           // Partial frame data
				else if (head_valid)
					next = st_armed;
			end
			st_armed: begin
				if (video.first && head_valid) begin
					show = 1'b1;              // Frame start meets display start
					next = st_stream;
				end
			end
			st_stream: begin
				if (video.de) begin
					if (head_valid)
						show = 1'b1;
					else
						next = st_seek;       // Lost lock, find next frame
				end
			end
			default: next = st_seek;
		endcase
	end

	assign starve = (state == st_stream) && video.de && !head_valid;

	// ====================
	// State and status
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			state    <= st_seek;
			underrun <= 1'b0;
		end else begin
			state <= next;
			if (starve)
				underrun <= 1'b1;             // Sticky
		end
	end

	assign head_ready = show | discard;       // Pop in the same cycle as use
	assign pixel      = head.pixel;
	assign black      = ~show;                // Nothing valid to show
	assign streaming  = state == st_stream;

endmodule

/* logic/pixel_out.sv */
// HDMI parallel port stage; widens RGB565 to RGB888, blanks and registers with the syncs
`timescale 1ns/1ns

module pixel_out import img_cap_pkg::*; (
	input  logic    clk_25_2m,
	input  logic    reset,
	input  video_t  video,
	input  rgb565_t pixel,
	input  logic    black,
	output rgb888_t hdmi_d,
	output logic    hdmi_de,
	output logic    hdmi_hs,
	output logic    hdmi_vs
);

	rgb888_t wide;  // Expanded color before blanking

	// Replicate top bits into the low end so full scale stays full scale
	always_comb begin
		wide.r = {pixel.r, pixel.r[4:2]};
		wide.g = {pixel.g, pixel.g[5:4]};
		wide.b = {pixel.b, pixel.b[4:2]};
	end

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			hdmi_d  <= '0;
			hdmi_de <= 1'b0;
			hdmi_hs <= 1'b1;    // Syncs idle high
			hdmi_vs <= 1'b1;
		end else begin
			hdmi_d  <= (video.de && !black) ? wide : '0;
			hdmi_de <= video.de;
			hdmi_hs <= video.hs;
			hdmi_vs <= video.vs;
		end
	end

endmodule

/* logic/img_cap_top.sv */
// Capture top level; camera in, HDMI out, status on the LEDs, all in one pixel clock domain
`timescale 1ns/1ns

module img_cap_top import img_cap_pkg::*; (
	input  logic       clk_25_2m,
	input  logic       reset,
	input  logic       cam_vsync,
	input  logic       cam_href,
	input  rgb565_t    cam_data,
	output rgb888_t    hdmi_d,
	output logic       hdmi_de,
	output logic       hdmi_hs,
	output logic       hdmi_vs,
	output logic       hdmi_clk,
	output logic [1:0] ledr,
	output logic       ledg
);

	cam_pixel_t  cap_pix;       // Capture to FIFO
	logic        cap_valid;
	logic        cap_ready;
	cam_pixel_t  head;          // FIFO to control
	logic        head_valid;
	logic        head_ready;
	video_t      video;
	rgb565_t     pixel;
	logic        black;
	img_status_t status;

	// ====================
	// Camera side
	// ====================
	cam_capture i_cap (
		.clk_25_2m, .reset, .cam_vsync, .cam_href, .cam_data,
		.pix(cap_pix), .pix_valid(cap_valid), .pix_ready(cap_ready),
		.overflow(status.overflow)
	);

	pixel_fifo #(.depth(fifo_depth)) i_fifo (
		.clk_25_2m, .reset,
		.in_data(cap_pix), .in_valid(cap_valid), .in_ready(cap_ready),
		.out_data(head), .out_valid(head_valid), .out_ready(head_ready)
	);

	// ====================
	// Display side
	// ====================
	video_timing i_timing (.clk_25_2m, .reset, .video);

	stream_ctrl i_ctrl (
		.clk_25_2m, .reset, .video, .head, .head_valid, .head_ready,
		.pixel, .black, .streaming(status.streaming), .underrun(status.underrun)
	);

	pixel_out i_out (
		.clk_25_2m, .reset, .video, .pixel, .black,
		.hdmi_d, .hdmi_de, .hdmi_hs, .hdmi_vs
	);

	assign hdmi_clk = clk_25_2m;                            // Pixel clock to the transmitter
	assign ledg     = status.streaming;
	assign ledr     = {status.underrun, status.overflow};   // Both sticky

endmodule

/* bench/img_cap_properties.sv */
// Concurrent checks on FIFO pointers and display syncs, bound into the FIFO and timing blocks
`timescale 1ns/1ns

module img_cap_properties import img_cap_pkg::*; (
	input logic                          clk_25_2m,
	input logic                          reset,
	input logic                          in_ready,
	input logic                          out_valid,
	input logic [$clog2(fifo_depth)-1:0] wr_ptr,
	input logic [$clog2(fifo_depth)-1:0] rd_ptr,
	input video_t                        video
);

	logic [7:0] hs_low_len;  // Length of the current hs pulse

	always_ff @(posedge clk_25_2m) begin
		if (!reset)
			hs_low_len <= '0;
		else
			hs_low_len <= video.hs ? 8'd0 : hs_low_len + 8'd1;
	end

	// Full FIFO takes no write
	assert property (@(posedge clk_25_2m) disable iff (!reset)
		!in_ready |=> wr_ptr == $past(wr_ptr)) else $error("write into full FIFO");
	// Empty FIFO gives no read
	assert property (@(posedge clk_25_2m) disable iff (!reset)
		!out_valid |=> rd_ptr == $past(rd_ptr)) else $error("read from empty FIFO");
	assert property (@(posedge clk_25_2m) disable iff (!reset)
		$rose(video.hs) |-> hs_low_len == 8'(h_sync)) else $error("hs pulse width wrong");
	assert property (@(posedge clk_25_2m) disable iff (!reset)
		!video.vs |-> !video.de) else $error("de during vertical sync");

endmodule

bind pixel_fifo img_cap_properties i_fifo_props (
	.clk_25_2m, .reset, .in_ready, .out_valid, .wr_ptr, .rd_ptr, .video(4'b1111)
);

bind video_timing img_cap_properties i_timing_props (
	.clk_25_2m, .reset, .in_ready(1'b1), .out_valid(1'b1), .wr_ptr('0), .rd_ptr('0), .video
);

/* bench/img_cap_tb.sv */
// Capture top level testbench; camera model in, HDMI port checked against a reference model
`timescale 1ns/1ns

module img_cap_tb import img_cap_pkg::*; ();

	logic       clk_25_2m = 1'b0;
	logic       reset;
	logic       cam_vsync;
	logic       cam_href;
	rgb565_t    cam_data;
	rgb888_t    hdmi_d;
	logic       hdmi_de;
	logic       hdmi_hs;
	logic       hdmi_vs;
	logic       hdmi_clk;
	logic [1:0] ledr;
	logic       ledg;

	integer      seed = 32'hef843337;  // Camera pixel values
	int unsigned cyc = 0;              // Clock edges since start
	int          t0;                   // cyc at the edge that releases reset
	rgb565_t     sent_q[$];            // Pixels of the current camera frame
	rgb888_t     exp_px;
	bit          compare_on;
	int          compared;             // Pixels checked against the queue
	int          stray;                // Nonzero data on de while not streaming
	int          first_cmp_cyc;
	int          errors;
	int          n_checks;
	int          n_tests;

	img_cap_top i_dut (.*);

	always #50 clk_25_2m = ~clk_25_2m;  // 100 ns period

	always @(posedge clk_25_2m)
		cyc <= cyc + 1;

	// ====================
	// Reference
	// ====================
	function automatic rgb888_t expand(rgb565_t p);
		rgb888_t w;
		w.r = (8'(p.r) << 3) | (8'(p.r) >> 2);  // Top bits refill the low end
		w.g = (8'(p.g) << 2) | (8'(p.g) >> 4);
		w.b = (8'(p.b) << 3) | (8'(p.b) >> 2);
		return w;
	endfunction

	// Compare on the falling edge where outputs are settled
	always @(negedge clk_25_2m) begin
		if (compare_on && hdmi_de) begin
			if (ledg) begin
				if (sent_q.size() == 0) begin
					$display("Extra pixel on hdmi_d at cycle %0d, nothing was sent for it", cyc);
					errors++;
				end else begin
					exp_px = expand(sent_q.pop_front());
					if (first_cmp_cyc < 0)
						first_cmp_cyc = cyc;   // Start of display
					if (hdmi_d !== exp_px) begin
						$display("CHECK FAILED hdmi_d got 0x%h expected 0x%h", hdmi_d, exp_px);
						errors++;
					end
					compared++;
				end
			end else if (hdmi_d !== '0) begin
				stray++;                       // Should be blank
			end
		end
	end

	// ====================
	// Helpers
	// ====================
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		n_checks++;
		if (got !== want) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic report_test(input string name, input int err_before);
		n_tests++;
		$display("test %0d %s: %s (%0d errors)", n_tests, name,
			(errors == err_before) ? "ok" : "bad", errors - err_before);
	endtask

	// Call on a rising edge; returns on the edge where cyc reaches target
	task automatic wait_until(input int target);
		int n;
		n = 0;
		while (cyc < target && n < 2 * h_total * v_total) begin
			@(posedge clk_25_2m);
			n++;
		end
		if (cyc < target) begin
			$display("Timeout waiting for cycle %0d, now at %0d", target, cyc);
			errors++;
		end
	endtask

	task automatic apply_reset(input bit check);
		@(posedge clk_25_2m);
		reset      <= 1'b0;
		cam_vsync  <= 1'b0;
		cam_href   <= 1'b0;
		cam_data   <= '0;
		compare_on = 1'b0;
		repeat (4) @(posedge clk_25_2m);
		if (check) begin
			#25;                             // Middle of the high phase
			check_value("hdmi_clk", hdmi_clk, 1);
			@(negedge clk_25_2m);            // Outputs held in reset
			check_value("hdmi_clk", hdmi_clk, 0);
			check_value("hdmi_hs", hdmi_hs, 1);
			check_value("hdmi_vs", hdmi_vs, 1);
			check_value("hdmi_de", hdmi_de, 0);
			check_value("hdmi_d", hdmi_d, 0);
			check_value("ledr", ledr, 0);
			check_value("ledg", ledg, 0);
		end
		@(posedge clk_25_2m);                // Release on the 5th cycle
		reset <= 1'b1;
		t0 = cyc;
		sent_q.delete();
		compared      = 0;
		stray         = 0;
		first_cmp_cyc = -1;
		compare_on    = 1'b1;
	endtask

	// vsync for vs_lines line periods, then lines of h_active pixels and idle
	task automatic send_camera(input int vs_lines, input int lines, input int first_pix,
		input bit record);
		rgb565_t px;
		wait_until(first_pix - vs_lines * h_total);
		for (int k = 0; k < vs_lines * h_total; k++) begin
			cam_vsync <= 1'b1;
			cam_href  <= 1'b0;
			@(posedge clk_25_2m);
		end
		for (int l = 0; l < lines; l++) begin
			for (int k = 0; k < h_total; k++) begin
				cam_vsync <= 1'b0;
				if (k < h_active) begin
					px = rgb565_t'(16'($random(seed)));
					cam_href <= 1'b1;
					cam_data <= px;
					if (record)
						sent_q.push_back(px);
				end else begin
					cam_href <= 1'b0;       // Line blanking
				end
				@(posedge clk_25_2m);
			end
		end
		cam_href <= 1'b0;
	endtask

	task automatic measure_timing();
		int de_total;
		int de_line0;
		int hs_line0;
		int vs_low;
		int de_lines;
		logic prev_de;
		de_total = 0;
		de_line0 = 0;
		hs_line0 = 0;
		vs_low   = 0;
		de_lines = 0;
		prev_de  = 1'b0;
		wait_until(t0 + 1);                  // First active pixel reaches the port
		for (int i = 0; i < h_total * v_total; i++) begin
			@(negedge clk_25_2m);
			de_total += hdmi_de;
			if (i < h_total) begin
				de_line0 += hdmi_de;
				hs_line0 += !hdmi_hs;
			end
			vs_low += !hdmi_vs;
			if (hdmi_de && !prev_de)
				de_lines++;                  // One rising de per active line
			prev_de = hdmi_de;
		end
		check_value("hdmi_de per line", de_line0, h_active);
		check_value("hdmi_hs low per line", hs_line0, h_sync);
		check_value("hdmi_de per frame", de_total, h_active * v_active);
		check_value("hdmi_de lines", de_lines, v_active);
		check_value("hdmi_vs low cycles", vs_low, v_sync * h_total);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		int e0;
		int base;
		reset     = 1'b0;
		cam_vsync = 1'b0;
		cam_href  = 1'b0;
		cam_data  = '0;
		errors    = 0;
		n_checks  = 0;
		n_tests   = 0;

		e0 = errors;
		apply_reset(1'b1);
		report_test("reset state", e0);

		e0 = errors;
		measure_timing();
		report_test("video timing", e0);

		// Partial frame first, then a full frame ahead of display frame 1
		e0 = errors;
		apply_reset(1'b0);
		base = t0 + 1 + h_total * v_total;   // Edge that pops display pixel 0
		send_camera(0, 20, t0 + 10, 1'b0);
		send_camera(3, v_active, base - 100, 1'b1);
		wait_until(base + v_active * h_total + 10);
		check_value("compared pixels", compared, h_active * v_active);
		check_value("pixels left", sent_q.size(), 0);
		check_value("ledg", ledg, 1);
		check_value("ledr", ledr, 0);
		report_test("image transfer", e0);

		e0 = errors;
		check_value("first pixel cycle", first_cmp_cyc, base + 1);
		check_value("stray pixels", stray, 0);
		report_test("frame lock", e0);

		// Camera stops after 100 lines
		e0 = errors;
		apply_reset(1'b0);
		base = t0 + 1 + h_total * v_total;
		send_camera(3, 100, base - 100, 1'b1);
		wait_until(base + 101 * h_total);
		check_value("ledr underrun", ledr[1], 1);
		check_value("ledg", ledg, 0);
		check_value("compared pixels", compared, 100 * h_active);
		check_value("stray pixels", stray, 0);
		wait_until(base + 110 * h_total);
		check_value("ledr underrun", ledr[1], 1);
		check_value("stray pixels", stray, 0);
		report_test("underrun", e0);

		// Frame start and two lines while control waits for frame 1
		e0 = errors;
		apply_reset(1'b0);
		send_camera(1, 2, t0 + 10 + h_total, 1'b0);
		wait_until(cyc + 50);
		check_value("ledr overflow", ledr[0], 1);
		wait_until(cyc + h_total);
		check_value("ledr overflow", ledr[0], 1);
		report_test("overflow", e0);

		finish_run();
	end

endmodule

/* list.f */
logic/img_cap_pkg.sv
logic/cam_capture.sv
logic/pixel_fifo.sv
logic/video_timing.sv
logic/stream_ctrl.sv
logic/pixel_out.sv
logic/img_cap_top.sv
bench/img_cap_properties.sv
bench/img_cap_tb.sv

/* Makefile */
# Verilator build and run of the capture testbench

VERILATOR ?= verilator
TOP       ?= img_cap_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat list.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
